// ==== design/tharness_pkg.sv ====
// Shared types, bus indices and the address map of the test harness.
// Imported by the bus interface and by every module that uses these definitions.

package tharness_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  // Lower host index wins arbitration
  typedef enum logic {
    Testutil = 1'b0,
    CoreData = 1'b1
  } host_e;

  typedef enum logic {
    Ram         = 1'b0,
    TestutilDev = 1'b1
  } device_e;

  localparam int unsigned NrHosts   = 2;
  localparam int unsigned NrDevices = 2;

  // Test utility register window of 1 kB
  localparam addr_t TestutilBase = 32'h0002_0000;
  localparam addr_t TestutilMask = 32'h0000_03FF;

  localparam addr_t HaltOffs     = 32'h0;
  localparam addr_t SigBeginOffs = 32'h4;
  localparam addr_t SigEndOffs   = 32'h8;

  typedef enum logic [1:0] {
    Idle,
    Issue,
    Wait,
    Done
  } testutil_state_e;

endpackage

// ==== design/mem_bus_if.sv ====
// One request/grant/read-valid bus link between a host and the xbar,
// or between the xbar and a device.

`timescale 1ns/1ns

interface mem_bus_if;

  import tharness_pkg::*;

  logic  req;
  logic  gnt;
  addr_t addr;
  logic  we;
  be_t   be;
  data_t wdata;
  logic  rvalid;
  data_t rdata;
  logic  err;

  modport host (
    output req, addr, we, be, wdata,
    input  gnt, rvalid, rdata, err
  );

  // Grant comes from the device side of a link
  modport device (
    input  req, addr, we, be, wdata,
    output gnt, rvalid, rdata, err
  );

endinterface

// ==== design/bus_xbar.sv ====
// Two-host, two-device bus with fixed-priority arbitration and address decode.
// Responses come back one cycle after the grant; unmapped addresses get err.

`timescale 1ns/1ns

module bus_xbar #(
  parameter int unsigned RamWords = 1024
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_bus_if.device host_0,
  mem_bus_if.device host_1,
  mem_bus_if.host   dev_0,
  mem_bus_if.host   dev_1
);

  import tharness_pkg::*;

  localparam addr_t RamMask = addr_t'(RamWords * 4 - 1);

  logic [NrHosts-1:0]   host_req;
  logic [NrDevices-1:0] dev_gnt;
  logic [NrDevices-1:0] dev_rvalid;
  host_e                win_host;
  addr_t                req_addr;
  logic                 req_we;
  be_t                  req_be;
  data_t                req_wdata;
  logic                 ram_hit;
  logic                 tu_hit;
  logic                 miss;
  device_e              sel_dev;
  logic                 dev_ready;
  logic                 accept;
  logic                 rsp_pending_q;
  logic                 rsp_miss_q;
  host_e                rsp_host_q;
  device_e              rsp_dev_q;
  logic                 rsp_rvalid;

  assign host_req[Testutil] = host_0.req;
  assign host_req[CoreData] = host_1.req;
  assign dev_gnt[Ram]            = dev_0.gnt;
  assign dev_gnt[TestutilDev]    = dev_1.gnt;
  assign dev_rvalid[Ram]         = dev_0.rvalid;
  assign dev_rvalid[TestutilDev] = dev_1.rvalid;

  // Test utility always wins
  assign win_host = host_req[Testutil] ? Testutil : CoreData;

  always_comb begin
    if (win_host == Testutil) begin
      req_addr  = host_0.addr;
      req_we    = host_0.we;
      req_be    = host_0.be;
      req_wdata = host_0.wdata;
    end else begin
      req_addr  = host_1.addr;
      req_we    = host_1.we;
      req_be    = host_1.be;
      req_wdata = host_1.wdata;
    end
  end

  assign ram_hit = (req_addr & ~RamMask) == '0;
  assign tu_hit  = (req_addr & ~TestutilMask) == TestutilBase;
  assign miss    = !ram_hit && !tu_hit;
  assign sel_dev = tu_hit ? TestutilDev : Ram;

  // A miss is granted too and answered locally
  assign dev_ready = miss || dev_gnt[sel_dev];
  assign accept    = (|host_req) && dev_ready;

  assign host_0.gnt = host_req[Testutil] && dev_ready;
  assign host_1.gnt = (win_host == CoreData) && host_req[CoreData] && dev_ready;

  assign dev_0.req   = (|host_req) && ram_hit;
  assign dev_0.addr  = req_addr;
  assign dev_0.we    = req_we;
  assign dev_0.be    = req_be;
  assign dev_0.wdata = req_wdata;
  assign dev_1.req   = (|host_req) && tu_hit;
  assign dev_1.addr  = req_addr;
  assign dev_1.we    = req_we;
  assign dev_1.be    = req_be;
  assign dev_1.wdata = req_wdata;

  // Routing for the response in the next cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rsp_pending_q <= 1'b0;
      rsp_miss_q    <= 1'b0;
      rsp_host_q    <= Testutil;
      rsp_dev_q     <= Ram;
    end else begin
      rsp_pending_q <= accept;
      if (accept) begin
        rsp_miss_q <= miss;
        rsp_host_q <= win_host;
        rsp_dev_q  <= sel_dev;
      end
    end
  end

  assign rsp_rvalid = rsp_pending_q && (rsp_miss_q || dev_rvalid[rsp_dev_q]);

  assign host_0.rvalid = rsp_rvalid && (rsp_host_q == Testutil);
  assign host_1.rvalid = rsp_rvalid && (rsp_host_q == CoreData);

  always_comb begin
    if (rsp_miss_q) begin
      host_0.rdata = '0;
      host_0.err   = 1'b1;
    end else if (rsp_dev_q == TestutilDev) begin
      host_0.rdata = dev_1.rdata;
      host_0.err   = dev_1.err;
    end else begin
      host_0.rdata = dev_0.rdata;
      host_0.err   = dev_0.err;
    end
  end

  assign host_1.rdata = host_0.rdata;
  assign host_1.err   = host_0.err;

endmodule

// ==== design/sram_1p.sv ====
// Single-port word RAM on a bus device link.
// Always accepts; byte-enable writes, read data one cycle after the request.

`timescale 1ns/1ns

module sram_1p #(
  parameter int unsigned RamWords = 1024
) (
  input  logic      clk_i,
  input  logic      arst_n_i,
  mem_bus_if.device bus
);

  import tharness_pkg::*;

  localparam int unsigned IdxBits = $clog2(RamWords);

  data_t              mem [RamWords];
  logic [IdxBits-1:0] word_idx;
  logic               rvalid_q;
  data_t              rdata_q;

  assign word_idx = bus.addr[IdxBits+1:2];
  assign bus.gnt  = bus.req;

  always_ff @(posedge clk_i) begin
    if (bus.req) begin
      if (bus.we) begin
        for (int i = 0; i < $bits(be_t); i++) begin
          if (bus.be[i]) begin
            mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[word_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= bus.req;
    end
  end

  assign bus.rvalid = rvalid_q;
  assign bus.rdata  = rdata_q;
  assign bus.err    = 1'b0;

endmodule

// ==== design/testutil.sv ====
// Test utility with a register window for the signature bounds and halt,
// plus a host engine that reads the signature range and streams it out.

`timescale 1ns/1ns

module testutil (
  input  logic                clk_i,
  input  logic                arst_n_i,
  mem_bus_if.device           dev,
  mem_bus_if.host             host,
  output logic                sig_valid_o,
  output tharness_pkg::data_t sig_data_o,
  output logic                done_o
);

  import tharness_pkg::*;

  testutil_state_e state_q;
  testutil_state_e state_d;
  addr_t           sig_begin_q;
  addr_t           sig_end_q;
  addr_t           cur_addr_q;
  addr_t           next_addr;
  addr_t           dev_offs;
  logic            dev_wr;
  logic            start;
  logic            reg_hit;
  data_t           reg_rdata;
  logic            dev_rvalid_q;
  logic            dev_err_q;
  data_t           dev_rdata_q;

  assign dev_offs = dev.addr & TestutilMask;
  assign dev_wr   = dev.req && dev.we;
  assign dev.gnt  = dev.req;

  always_comb begin
    reg_hit   = 1'b1;
    reg_rdata = '0;
    case (dev_offs)
      HaltOffs:     reg_rdata = {31'b0, state_q == Done};
      SigBeginOffs: reg_rdata = sig_begin_q;
      SigEndOffs:   reg_rdata = sig_end_q;
      default:      reg_hit   = 1'b0;
    endcase
  end

  // Halt only counts while the engine is idle
  assign start = dev_wr && (dev_offs == HaltOffs) && (state_q == Idle);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sig_begin_q  <= '0;
      sig_end_q    <= '0;
      dev_rvalid_q <= 1'b0;
    end else begin
      dev_rvalid_q <= dev.req;
      if (dev_wr && dev_offs == SigBeginOffs) begin
        sig_begin_q <= dev.wdata;
      end
      if (dev_wr && dev_offs == SigEndOffs) begin
        sig_end_q <= dev.wdata;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (dev.req) begin
      dev_err_q   <= !reg_hit;
      dev_rdata_q <= dev.we ? '0 : reg_rdata;
    end
  end

  assign dev.rvalid = dev_rvalid_q;
  assign dev.rdata  = dev_rdata_q;
  assign dev.err    = dev_err_q;

  assign next_addr = cur_addr_q + addr_t'(4);

  // Dump engine with one word in flight at a time
  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle:    if (start) state_d = (sig_begin_q >= sig_end_q) ? Done : Issue;
      Issue:   if (host.gnt) state_d = Wait;
      Wait:    if (host.rvalid) state_d = (next_addr >= sig_end_q) ? Done : Issue;
      Done:    state_d = Done;
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q    <= Idle;
      cur_addr_q <= '0;
    end else begin
      state_q <= state_d;
      if (start) begin
        cur_addr_q <= sig_begin_q;
      end else if (state_q == Wait && host.rvalid) begin
        cur_addr_q <= next_addr;
      end
    end
  end

  assign host.req   = (state_q == Issue);
  assign host.addr  = cur_addr_q;
  assign host.we    = 1'b0;
  assign host.be    = '1;
  assign host.wdata = '0;

  // Strobe in the cycle the word comes back
  assign sig_valid_o = (state_q == Wait) && host.rvalid;
  assign sig_data_o  = host.rdata;
  assign done_o      = (state_q == Done);

endmodule

// ==== design/tharness_top.sv ====
// Test harness top level joining the external host port, bus xbar, RAM and test utility.
// The external port stands in for a processor data port on host link 1.

`timescale 1ns/1ns

module tharness_top #(
  parameter int unsigned RamWords = 1024
) (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  tharness_pkg::addr_t addr_i,
  input  tharness_pkg::be_t   be_i,
  input  tharness_pkg::data_t wdata_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output logic                err_o,
  output tharness_pkg::data_t rdata_o,
  output logic                sig_valid_o,
  output tharness_pkg::data_t sig_data_o,
  output logic                done_o
);

  // Host links 0 and 1, device links 0 and 1
  mem_bus_if tu_host_bus ();
  mem_bus_if ext_bus ();
  mem_bus_if ram_bus ();
  mem_bus_if tu_dev_bus ();

  assign ext_bus.req   = req_i;
  assign ext_bus.we    = we_i;
  assign ext_bus.addr  = addr_i;
  assign ext_bus.be    = be_i;
  assign ext_bus.wdata = wdata_i;
  assign gnt_o         = ext_bus.gnt;
  assign rvalid_o      = ext_bus.rvalid;
  assign err_o         = ext_bus.err;
  assign rdata_o       = ext_bus.rdata;

  bus_xbar #(
    .RamWords (RamWords)
  ) u_xbar (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .host_0   (tu_host_bus.device),
    .host_1   (ext_bus.device),
    .dev_0    (ram_bus.host),
    .dev_1    (tu_dev_bus.host)
  );

  sram_1p #(
    .RamWords (RamWords)
  ) u_ram (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .bus      (ram_bus.device)
  );

  testutil u_testutil (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .dev         (tu_dev_bus.device),
    .host        (tu_host_bus.host),
    .sig_valid_o (sig_valid_o),
    .sig_data_o  (sig_data_o),
    .done_o      (done_o)
  );

endmodule

// ==== sim/tb_clkgen.sv ====
// Clock and reset source for the test harness testbench.
// Reset is held low for a few cycles at start and again after each rerun_i pulse.

`timescale 1ns/1ns

module tb_clkgen #(
  parameter int unsigned PeriodNs  = 8,
  parameter int unsigned RstCycles = 3
) (
  input  logic rerun_i,
  output logic clk_o,
  output logic arst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PeriodNs / 2) clk_o = ~clk_o;
  end

  // Release lines up with the testbench drive point after the edge
  initial begin
    arst_n_o = 1'b0;
    forever begin
      repeat (RstCycles) @(posedge clk_o);
      #1 arst_n_o = 1'b1;
      @(posedge rerun_i);
      arst_n_o = 1'b0;
    end
  end

endmodule

// ==== sim/tharness_assertions.sv ====
// Bus protocol and signature stream properties of the test harness.
// Bound into the top level; fail_cnt is read by the testbench at the end of the run.

`timescale 1ns/1ns

module tharness_assertions (
  input logic clk_i,
  input logic arst_n_i,
  input logic req_i,
  input logic gnt_o,
  input logic rvalid_o,
  input logic sig_valid_o,
  input logic done_o,
  input logic tu_req_i
);

  int unsigned fail_cnt = 0;

  rvalid_after_accept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_i && gnt_o |=> rvalid_o)
    else begin
      fail_cnt++;
      $error("no response one cycle after an accepted request");
    end

  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    gnt_o |-> req_i)
    else begin
      fail_cnt++;
      $error("grant without a request");
    end

  // Engine requests take priority over the external port
  engine_blocks_ext: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tu_req_i |-> !gnt_o)
    else begin
      fail_cnt++;
      $error("external grant while the dump engine requests");
    end

  no_strobe_after_done: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_o |-> !sig_valid_o)
    else begin
      fail_cnt++;
      $error("signature strobe while done is high");
    end

  done_sticky: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    done_o |=> done_o)
    else begin
      fail_cnt++;
      $error("done fell without a reset");
    end

endmodule

bind tharness_top tharness_assertions u_assertions (
  .clk_i       (clk_i),
  .arst_n_i    (arst_n_i),
  .req_i       (req_i),
  .gnt_o       (gnt_o),
  .rvalid_o    (rvalid_o),
  .sig_valid_o (sig_valid_o),
  .done_o      (done_o),
  .tu_req_i    (tu_host_bus.req)
);

// ==== sim/tharness_tb.sv ====
// Testbench for the test harness. Drives the external host port against a
// reference RAM model, runs two signature dumps and counts every mismatch.

`timescale 1ns/1ns

module tharness_tb;

  import tharness_pkg::*;

  localparam int unsigned RamWords  = 1024;
  localparam int unsigned SigWords  = 16;
  localparam int unsigned NrBusOps  = 80;
  localparam int unsigned PeriodNs  = 8;
  localparam int unsigned TimeoutNs = 2 * (20 * NrBusOps + 4 * SigWords) * PeriodNs;

  typedef logic [$clog2(RamWords)-1:0] widx_t;

  logic  clk, arst_n, rerun;
  logic  req, we, gnt, rvalid, err, sig_valid, done;
  addr_t addr;
  be_t   be;
  data_t wdata, rdata, sig_data;

  data_t       ref_mem [RamWords];
  data_t       sig_q [$];
  int unsigned errors;
  int unsigned assert_fails;

  tb_clkgen #(.PeriodNs(PeriodNs), .RstCycles(3)) u_clkgen (
    .rerun_i (rerun), .clk_o (clk), .arst_n_o (arst_n)
  );

  tharness_top #(.RamWords(RamWords)) u_dut (
    .clk_i (clk), .arst_n_i (arst_n), .req_i (req), .we_i (we),
    .addr_i (addr), .be_i (be), .wdata_i (wdata),
    .gnt_o (gnt), .rvalid_o (rvalid), .err_o (err), .rdata_o (rdata),
    .sig_valid_o (sig_valid), .sig_data_o (sig_data), .done_o (done)
  );

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, be_t b);
    data_t res;
    res = old_w;
    for (int i = 0; i < 4; i++) begin
      if (b[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // Holds the request until granted, then collects the response
  task automatic bus_access(input addr_t a, input logic w, input be_t b, input data_t d,
                            output data_t rd, output logic e);
    req = 1'b1;
    we = w;
    addr = a;
    be = b;
    wdata = d;
    @(negedge clk);
    while (!gnt) @(negedge clk);
    @(posedge clk);
    #1 req = 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    rd = rdata;
    e = err;
    @(posedge clk);
    #1;
  endtask

  task automatic write_ok(input addr_t a, input be_t b, input data_t d);
    data_t rd;
    logic  e;
    bus_access(a, 1'b1, b, d, rd, e);
    if (e !== 1'b0) begin
      errors++;
      $display("CHECK FAILED at %0t: write to 0x%08h returned err", $time, a);
    end
  endtask

  task automatic read_check(input addr_t a, input data_t exp);
    data_t rd;
    logic  e;
    bus_access(a, 1'b0, 4'hF, '0, rd, e);
    if (rd !== exp || e !== 1'b0) begin
      errors++;
      $display("CHECK FAILED at %0t: read 0x%08h gave 0x%08h err %0b, expected 0x%08h",
               $time, a, rd, e, exp);
    end
  endtask

  task automatic expect_error(input addr_t a, input logic w);
    data_t rd;
    logic  e;
    bus_access(a, w, 4'hF, 32'hA5A5_A5A5, rd, e);
    if (e !== 1'b1 || rd !== '0) begin
      errors++;
      $display("CHECK FAILED at %0t: access 0x%08h we %0b gave err %0b data 0x%08h",
               $time, a, w, e, rd);
    end
  endtask

  task automatic ram_write(input widx_t idx, input be_t b, input data_t d);
    ref_mem[idx] = merge_bytes(ref_mem[idx], d, b);
    write_ok({idx, 2'b00}, b, d);
  endtask

  always @(negedge clk) begin
    if (sig_valid) sig_q.push_back(sig_data);
  end

  initial begin
    #(TimeoutNs);
    $display("Watchdog expired after %0d ns, the run did not complete", TimeoutNs);
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    data_t d;
    widx_t w;
    void'($urandom(35));
    {req, we, addr, be, wdata, rerun} = '0;
    errors = 0;
    @(posedge arst_n);
    @(posedge clk);
    #1;
    // Full words first so partial writes merge onto known data
    for (int i = 0; i < SigWords; i++) ram_write(widx_t'(i), 4'hF, $urandom());
    for (int i = 0; i < 24; i++) begin
      w = widx_t'($urandom_range(SigWords - 1, 0));
      ram_write(w, be_t'($urandom()), $urandom());
    end
    for (int i = 0; i < SigWords; i++) read_check(addr_t'(i * 4), ref_mem[i]);
    expect_error(32'h0004_0000, 1'b1);
    expect_error(32'h0004_0000, 1'b0);
    // Register window
    d = $urandom();
    write_ok(TestutilBase + SigBeginOffs, 4'hF, d);
    read_check(TestutilBase + SigBeginOffs, d);
    d = $urandom();
    write_ok(TestutilBase + SigEndOffs, 4'hF, d);
    read_check(TestutilBase + SigEndOffs, d);
    expect_error(TestutilBase + 32'hC, 1'b0);
    // Dump of words 0 to 15 with external traffic on other words meanwhile
    write_ok(TestutilBase + SigBeginOffs, 4'hF, 32'h0);
    write_ok(TestutilBase + SigEndOffs, 4'hF, addr_t'(SigWords * 4));
    sig_q.delete();
    write_ok(TestutilBase + HaltOffs, 4'hF, 32'h1);
    // Idle cycle first so each request meets one from the dump engine
    for (int i = 64; i < 68; i++) begin
      @(posedge clk);
      #1;
      ram_write(widx_t'(i), 4'hF, $urandom());
    end
    for (int i = 64; i < 68; i++) begin
      @(posedge clk);
      #1;
      read_check(addr_t'(i * 4), ref_mem[i]);
    end
    while (!done) @(negedge clk);
    if (sig_q.size() != SigWords) begin
      errors++;
      $display("CHECK FAILED at %0t: %0d signature strobes, expected %0d",
               $time, sig_q.size(), SigWords);
    end
    for (int i = 0; i < sig_q.size() && i < SigWords; i++) begin
      if (sig_q[i] !== ref_mem[i]) begin
        errors++;
        $display("CHECK FAILED at %0t: signature word %0d is 0x%08h, expected 0x%08h",
                 $time, i, sig_q[i], ref_mem[i]);
      end
    end
    // Empty range after a fresh reset
    @(posedge clk);
    #1 rerun = 1'b1;
    @(posedge arst_n);
    rerun = 1'b0;
    @(posedge clk);
    #1;
    sig_q.delete();
    write_ok(TestutilBase + SigBeginOffs, 4'hF, 32'h20);
    write_ok(TestutilBase + SigEndOffs, 4'hF, 32'h20);
    write_ok(TestutilBase + HaltOffs, 4'hF, 32'h1);
    while (!done) @(negedge clk);
    repeat (4) @(posedge clk);
    if (sig_q.size() != 0) begin
      errors++;
      $display("CHECK FAILED at %0t: %0d strobes for an empty range", $time, sig_q.size());
    end
    assert_fails = u_dut.u_assertions.fail_cnt;
    $display("Errors: %0d data checks, %0d assertions", errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== tharness.f ====
design/tharness_pkg.sv
design/mem_bus_if.sv
design/bus_xbar.sv
design/sram_1p.sv
design/testutil.sv
design/tharness_top.sv
sim/tb_clkgen.sv
sim/tharness_assertions.sv
sim/tharness_tb.sv

// ==== Makefile ====
TOP := tharness_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): tharness.f $(wildcard design/*.sv sim/*.sv)
	verilator --binary --timing --assert --timescale 1ns/1ns --top-module $(TOP) -f tharness.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "^TEST PASS$$" sim.log

lint:
	verilator --lint-only -Wall --timescale 1ns/1ns --top-module tharness_top \
	  design/tharness_pkg.sv design/mem_bus_if.sv design/bus_xbar.sv \
	  design/sram_1p.sv design/testutil.sv design/tharness_top.sv

clean:
	rm -rf obj_dir sim.log
